//--- design/cpu_defs.svh
// Word and register index widths, reset PC, opcode and funct codes
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define PC_INIT     32'h0000_0000

// Primary opcodes, instr[31:26]
`define OP_RTYPE    6'h00
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0D
`define OP_LUI      6'h0F
`define OP_LW       6'h23
`define OP_SW       6'h2B
`define OP_HALT     6'h3F

// R-type funct codes, instr[5:0]
`define FN_SLL      6'h00
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2A

`endif

//--- design/cpu_types_pkg.sv
// CPU type package: word and index types, ALU op enum, control bundle, pipeline payloads
`default_nettype none

`include "cpu_defs.svh"

package cpu_types_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_t;

    // Control bundle produced in decode, 11 bits
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    reg_dst;
        logic    mem_to_reg;
        logic    reg_wen;
        logic    dmem_ren;
        logic    dmem_wen;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rdat1;
        word_t     rdat2;
        word_t     imm_ext;
        logic [4:0] shamt;
        reg_addr_t rt;
        reg_addr_t rd;
    } idex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     rdat2;
        reg_addr_t dest;
    } exmem_t;

    // Only the writeback controls survive past memory
    typedef struct packed {
        logic      mem_to_reg;
        logic      reg_wen;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dest;
    } memwb_t;

endpackage

`default_nettype wire

//--- design/control_unit.sv
// Control unit: opcode and funct decode into the control bundle, immediate extension
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module control_unit import cpu_types_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl,
    output word_t imm_ext
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       sign_ext;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Default is a no-op with no register write
        ctrl = '0;
        case (opcode)
            `OP_RTYPE: begin
                ctrl.reg_dst = 1'b1;
                ctrl.reg_wen = 1'b1;
                case (funct)
                    `FN_ADDU: ctrl.alu_op = ALU_ADD;
                    `FN_SUBU: ctrl.alu_op = ALU_SUB;
                    `FN_AND:  ctrl.alu_op = ALU_AND;
                    `FN_OR:   ctrl.alu_op = ALU_OR;
                    `FN_SLT:  ctrl.alu_op = ALU_SLT;
                    `FN_SLL:  ctrl.alu_op = ALU_SLL;
                    default:  ctrl.reg_wen = 1'b0;
                endcase
            end
            `OP_ADDIU: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = ALU_ADD;
            end
            `OP_ORI: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = ALU_OR;
            end
            `OP_LUI: begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = ALU_LUI;
            end
            `OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_wen    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.dmem_ren   = 1'b1;
                ctrl.alu_op     = ALU_ADD;
            end
            `OP_SW: begin
                ctrl.alu_src  = 1'b1;
                ctrl.dmem_wen = 1'b1;
                ctrl.alu_op   = ALU_ADD;
            end
            `OP_HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    // Arithmetic and address immediates are signed, logical ones are not
    assign sign_ext = (opcode == `OP_ADDIU) || (opcode == `OP_LW) || (opcode == `OP_SW);
    assign imm_ext  = {{(`WORD_W-16){sign_ext & instr[15]}}, instr[15:0]};

endmodule

`default_nettype wire

//--- design/register_file.sv
// Register file: 32 words, register zero hardwired, write-through on reads
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module register_file import cpu_types_pkg::*; (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      wen,
    input  reg_addr_t wsel,
    input  word_t     wdat,
    input  reg_addr_t rsel1,
    input  reg_addr_t rsel2,
    output word_t     rdat1,
    output word_t     rdat2
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    word_t regs [NUM_REGS];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdat;
        end
    end

    // A write in flight is visible to a read in the same cycle
    function automatic word_t read_port(input reg_addr_t sel);
        if (sel == '0)
            return '0;
        else if (wen && (wsel == sel))
            return wdat;
        else
            return regs[sel];
    endfunction

    assign rdat1 = read_port(rsel1);
    assign rdat2 = read_port(rsel2);

endmodule

`default_nettype wire

//--- design/alu.sv
// ALU: add, subtract, and, or, signed set-less-than, shift left, load upper
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module alu import cpu_types_pkg::*; (
    input  alu_op_t    alu_op,
    input  word_t      port_a,
    input  word_t      port_b,
    input  logic [4:0] shamt,
    output word_t      result
);

    logic a_lt_b;

    // Signed compare for SLT
    assign a_lt_b = $signed(port_a) < $signed(port_b);

    always_comb begin
        case (alu_op)
            ALU_ADD: result = port_a + port_b;
            ALU_SUB: result = port_a - port_b;
            ALU_AND: result = port_a & port_b;
            ALU_OR:  result = port_a | port_b;
            ALU_SLT: result = {{(`WORD_W-1){1'b0}}, a_lt_b};
            ALU_SLL: result = port_b << shamt;
            // Immediate lands in the upper half word
            ALU_LUI: result = port_b << (`WORD_W / 2);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/datapath.sv
// Pipelined datapath top: PC, IF/ID, ID/EX, EX/MEM, MEM/WB registers, stage muxes, memory ports
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module datapath import cpu_types_pkg::*; (
    input  logic  CLK,
    input  logic  rst_n,
    input  logic  ihit,
    input  word_t imem_load,
    output word_t imem_addr,
    input  word_t dmem_load,
    output word_t dmem_addr,
    output word_t dmem_store,
    output logic  dmem_ren,
    output logic  dmem_wen,
    output logic  halt
);

    // Program counter and stage registers
    word_t  pc;
    ifid_t  ifid;
    idex_t  idex;
    exmem_t exmem;
    memwb_t memwb;

    // Whole pipeline moves together
    logic advance;

    // Decode stage signals
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    reg_addr_t id_rd;
    ctrl_t     id_ctrl;
    word_t     id_imm_ext;
    word_t     id_rdat1;
    word_t     id_rdat2;

    // Execute stage signals
    word_t     ex_port_b;
    word_t     ex_result;
    reg_addr_t ex_dest;

    // Writeback stage signals
    word_t     wb_wdat;

    assign advance = ihit && !exmem.ctrl.halt;

    // Instruction fields from IF/ID
    assign id_rs = ifid.instr[25:21];
    assign id_rt = ifid.instr[20:16];
    assign id_rd = ifid.instr[15:11];

    control_unit u_control_unit (
        .instr   (ifid.instr),
        .ctrl    (id_ctrl),
        .imm_ext (id_imm_ext)
    );

    register_file u_register_file (
        .CLK   (CLK),
        .rst_n (rst_n),
        .wen   (memwb.reg_wen),
        .wsel  (memwb.dest),
        .wdat  (wb_wdat),
        .rsel1 (id_rs),
        .rsel2 (id_rt),
        .rdat1 (id_rdat1),
        .rdat2 (id_rdat2)
    );

    // Operand B is the immediate for I-type, rt otherwise
    assign ex_port_b = idex.ctrl.alu_src ? idex.imm_ext : idex.rdat2;

    alu u_alu (
        .alu_op (idex.ctrl.alu_op),
        .port_a (idex.rdat1),
        .port_b (ex_port_b),
        .shamt  (idex.shamt),
        .result (ex_result)
    );

    // R-type writes rd, I-type writes rt
    assign ex_dest = idex.ctrl.reg_dst ? idex.rd : idex.rt;

    // Writeback data select
    assign wb_wdat = memwb.mem_to_reg ? memwb.load_data : memwb.alu_result;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc    <= `PC_INIT;
            ifid  <= '0;
            idex  <= '0;
            exmem <= '0;
            memwb <= '0;
        end else if (advance) begin
            pc <= pc + word_t'(4);

            // Fetch
            ifid.instr <= imem_load;

            // Decode outputs meet here
            idex.ctrl    <= id_ctrl;
            idex.rdat1   <= id_rdat1;
            idex.rdat2   <= id_rdat2;
            idex.imm_ext <= id_imm_ext;
            idex.shamt   <= ifid.instr[10:6];
            idex.rt      <= id_rt;
            idex.rd      <= id_rd;

            // Execute
            exmem.ctrl       <= idex.ctrl;
            exmem.alu_result <= ex_result;
            exmem.rdat2      <= idex.rdat2;
            exmem.dest       <= ex_dest;

            // Memory, load data captured same cycle
            memwb.mem_to_reg <= exmem.ctrl.mem_to_reg;
            memwb.reg_wen    <= exmem.ctrl.reg_wen;
            memwb.alu_result <= exmem.alu_result;
            memwb.load_data  <= dmem_load;
            memwb.dest       <= exmem.dest;
        end
    end

    // External ports
    assign imem_addr  = pc;
    assign dmem_addr  = exmem.alu_result;
    assign dmem_store = exmem.rdat2;
    assign dmem_ren   = exmem.ctrl.dmem_ren;
    assign dmem_wen   = exmem.ctrl.dmem_wen;
    // Stays high because EX/MEM freezes once HALT arrives
    assign halt       = exmem.ctrl.halt;

endmodule

`default_nettype wire

//--- verif/datapath_properties.sv
// Datapath port properties: reset state, stall hold, halt behavior, plus the bind into datapath
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module datapath_properties import cpu_types_pkg::*; (
    input logic  CLK,
    input logic  rst_n,
    input logic  ihit,
    input word_t imem_addr,
    input logic  dmem_ren,
    input logic  dmem_wen,
    input logic  halt
);

    int fail_count = 0;

    reset_state: assert property (@(posedge CLK)
        !rst_n |=> (imem_addr == `PC_INIT) && !dmem_ren && !dmem_wen && !halt)
        else begin
            $error("outputs not in reset state after a reset cycle");
            fail_count++;
        end

    // Nothing moves on an edge with ihit low
    stall_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        !ihit |=> $stable(imem_addr) && $stable(dmem_wen) && $stable(halt))
        else begin
            $error("outputs changed across a stalled edge");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge CLK) disable iff (!rst_n)
        halt |=> halt)
        else begin
            $error("halt dropped before reset");
            fail_count++;
        end

    halt_quiet: assert property (@(posedge CLK) disable iff (!rst_n)
        halt |-> !dmem_wen && !dmem_ren)
        else begin
            $error("memory access while halted");
            fail_count++;
        end

endmodule

bind datapath datapath_properties u_props (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .ihit      (ihit),
    .imem_addr (imem_addr),
    .dmem_ren  (dmem_ren),
    .dmem_wen  (dmem_wen),
    .halt      (halt)
);

`default_nettype wire

//--- verif/datapath_tb.sv
// Datapath testbench: clock, reset, memory models, program with expected stores, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module datapath_tb import cpu_types_pkg::*; ();

    localparam int    CLK_PERIOD = 4;
    localparam int    IMEM_WORDS = 128;
    localparam int    DMEM_WORDS = 64;
    localparam int    MAX_STORES = 16;
    localparam word_t LOAD_ADDR  = 32'h0000_0040;

    logic   CLK = 1'b0;
    logic   rst_n = 1'b0;
    logic   ihit = 1'b0;
    word_t  imem_load;
    word_t  imem_addr;
    word_t  dmem_load;
    word_t  dmem_addr;
    word_t  dmem_store;
    logic   dmem_ren;
    logic   dmem_wen;
    logic   halt;

    word_t  imem [IMEM_WORDS];
    word_t  dmem [DMEM_WORDS];
    // Register values predicted from the instruction rules
    word_t  rm [32];
    word_t  exp_addr [MAX_STORES];
    word_t  exp_data [MAX_STORES];
    string  exp_name [MAX_STORES];
    int     num_stores = 0;
    int     head = 0;
    int     prog_len = 0;
    int     mismatches = 0;
    int     other_errors = 0;
    integer seed = 32'h9b11;

    datapath uut (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .ihit       (ihit),
        .imem_load  (imem_load),
        .imem_addr  (imem_addr),
        .dmem_load  (dmem_load),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .halt       (halt)
    );

    // Preload pattern from the full byte address
    function automatic word_t fill_word(input word_t addr);
        return 32'hd00d_0000 ^ (addr * 32'h0001_0001);
    endfunction

    function automatic word_t sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic set_reg(input reg_addr_t r, input word_t v);
        if (r != '0)
            rm[r] = v;
    endtask

    // One instruction then two no-ops, so any later instruction may use its result
    task automatic emit(input word_t instr);
        imem[prog_len] = instr;
        prog_len += 3;
    endtask

    task automatic do_imm(input logic [5:0] op, input reg_addr_t rt, input reg_addr_t rs,
                          input logic [15:0] imm);
        word_t res;
        case (op)
            `OP_ADDIU: res = rm[rs] + sext(imm);
            `OP_ORI:   res = rm[rs] | {16'h0000, imm};
            default:   res = {imm, 16'h0000};
        endcase
        set_reg(rt, res);
        emit({op, rs, rt, imm});
    endtask

    task automatic do_rtype(input logic [5:0] funct, input reg_addr_t rd, input reg_addr_t rs,
                            input reg_addr_t rt, input logic [4:0] shamt);
        word_t res;
        case (funct)
            `FN_ADDU: res = rm[rs] + rm[rt];
            `FN_SUBU: res = rm[rs] - rm[rt];
            `FN_AND:  res = rm[rs] & rm[rt];
            `FN_OR:   res = rm[rs] | rm[rt];
            `FN_SLT:  res = ($signed(rm[rs]) < $signed(rm[rt])) ? 32'd1 : 32'd0;
            default:  res = rm[rt] << shamt;
        endcase
        set_reg(rd, res);
        emit({`OP_RTYPE, rs, rt, rd, shamt, funct});
    endtask

    task automatic do_lw(input reg_addr_t rt, input reg_addr_t base, input logic [15:0] off);
        set_reg(rt, fill_word(rm[base] + sext(off)));
        emit({`OP_LW, base, rt, off});
    endtask

    task automatic do_sw(input reg_addr_t rt, input reg_addr_t base, input logic [15:0] off,
                         input string name);
        exp_addr[num_stores] = rm[base] + sext(off);
        exp_data[num_stores] = rm[rt];
        exp_name[num_stores] = name;
        num_stores++;
        emit({`OP_SW, base, rt, off});
    endtask

    task automatic build_program();
        foreach (rm[i])
            rm[i] = '0;
        foreach (imem[i])
            imem[i] = '0;
        do_imm(`OP_ADDIU, 5'd1, 5'd0, 16'h0123);
        // Negative immediate
        do_imm(`OP_ADDIU, 5'd2, 5'd0, 16'hff00);
        // Top bit set, zero-extended anyway
        do_imm(`OP_ORI, 5'd3, 5'd0, 16'h8421);
        do_imm(`OP_LUI, 5'd4, 5'd0, 16'hbeef);
        do_imm(`OP_ADDIU, 5'd10, 5'd0, 16'h0080);
        do_sw(5'd2, 5'd10, 16'h0000, "addiu_neg");
        do_sw(5'd3, 5'd10, 16'h0004, "ori_zext");
        do_sw(5'd4, 5'd10, 16'h0008, "lui");
        do_rtype(`FN_ADDU, 5'd5, 5'd1, 5'd2, 5'd0);
        do_rtype(`FN_SUBU, 5'd6, 5'd1, 5'd2, 5'd0);
        // Overlapping operands so and, or and add all differ
        do_rtype(`FN_AND, 5'd7, 5'd2, 5'd3, 5'd0);
        do_rtype(`FN_OR, 5'd8, 5'd2, 5'd3, 5'd0);
        do_rtype(`FN_SLT, 5'd9, 5'd2, 5'd1, 5'd0);
        do_rtype(`FN_SLL, 5'd11, 5'd0, 5'd3, 5'd4);
        do_sw(5'd5, 5'd10, 16'h000c, "addu");
        do_sw(5'd6, 5'd10, 16'h0010, "subu");
        do_sw(5'd7, 5'd10, 16'h0014, "and");
        do_sw(5'd8, 5'd10, 16'h0018, "or");
        do_sw(5'd9, 5'd10, 16'h001c, "slt");
        do_sw(5'd11, 5'd10, 16'h0020, "sll");
        // Write to register zero is dropped
        do_imm(`OP_ADDIU, 5'd0, 5'd1, 16'h0005);
        do_sw(5'd0, 5'd10, 16'h0024, "r0_zero");
        do_lw(5'd12, 5'd0, LOAD_ADDR[15:0]);
        do_sw(5'd12, 5'd10, 16'h0028, "lw_data");
        // Stores right behind HALT must never reach memory
        imem[prog_len]     = {`OP_HALT, 26'h0};
        imem[prog_len + 1] = {`OP_SW, 5'd10, 5'd1, 16'h0030};
        imem[prog_len + 2] = {`OP_SW, 5'd10, 5'd2, 16'h0034};
        prog_len += 3;
    endtask

    assign imem_load = imem[imem_addr[8:2]];
    assign dmem_load = dmem[dmem_addr[7:2]];

    always @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= fill_word(word_t'(i) << 2);
            end
        end else if (dmem_wen) begin
            dmem[dmem_addr[7:2]] <= dmem_store;
        end
    end

    // Store leaves the memory stage only on an advancing edge
    always @(posedge CLK) begin
        if (rst_n && dmem_wen && ihit && head < num_stores) begin
            head <= head + 1;
        end
    end

    store_expected: assert property (@(posedge CLK) disable iff (!rst_n)
        dmem_wen |-> head < num_stores)
        else begin
            other_errors++;
            $display("ERROR: unexpected store to address %h", $sampled(dmem_addr));
        end

    store_addr: assert property (@(posedge CLK) disable iff (!rst_n)
        (dmem_wen && head < num_stores) |-> dmem_addr == exp_addr[head])
        else begin
            mismatches++;
            $display("MISMATCH %s addr expected %h actual %h", exp_name[$sampled(head)],
                     exp_addr[$sampled(head)], $sampled(dmem_addr));
        end

    store_data: assert property (@(posedge CLK) disable iff (!rst_n)
        (dmem_wen && head < num_stores) |-> dmem_store == exp_data[head])
        else begin
            mismatches++;
            $display("MISMATCH %s data expected %h actual %h", exp_name[$sampled(head)],
                     exp_data[$sampled(head)], $sampled(dmem_store));
        end

    // Only the single load in the program puts LOAD_ADDR on the bus
    load_ren: assert property (@(posedge CLK) disable iff (!rst_n)
        dmem_ren == (dmem_addr == LOAD_ADDR))
        else begin
            mismatches++;
            $display("MISMATCH load_ren expected %b actual %b",
                     $sampled(dmem_addr) == LOAD_ADDR, $sampled(dmem_ren));
        end

    halt_drained: assert property (@(posedge CLK) disable iff (!rst_n)
        $rose(halt) |-> head == num_stores)
        else begin
            other_errors++;
            $display("ERROR: halt rose with %0d expected stores missing",
                     num_stores - $sampled(head));
        end

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Instruction memory answers about three cycles in four
    always @(posedge CLK) begin
        #1;
        ihit = ($random(seed) & 32'd3) != 32'd0;
    end

    initial begin
        build_program();
        repeat (3) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        wait (halt === 1'b1);
        // A few frozen cycles for the halt properties
        repeat (8) @(posedge CLK);
        $display("errors: mismatches %0d, other %0d, properties %0d",
                 mismatches, other_errors, uut.u_props.fail_count);
        if (mismatches + other_errors + uut.u_props.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #1;
        // Ten cycles per program word, four times over for stalls
        #(10 * prog_len * CLK_PERIOD * 4);
        $display("ERROR: watchdog expired before halt rose, run stopped");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/cpu_types_pkg.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/datapath.sv
verif/datapath_properties.sv
verif/datapath_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the datapath simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module datapath_tb -o datapath_sim

output=$(./obj_dir/datapath_sim +verilator+error+limit+100) || true
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
fi
exit 1
